/* sources.f */
design/core_pkg.sv
design/instr_decoder.sv
design/scoreboard_fifo.sv
design/commit_stage.sv
design/mini_core.sv
dv/tb_mini_core.sv

/* Makefile */
# Verilator build and run for the mini core testbench
# Example: make run SEED=4242 LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 13964

PASS_MSG  := Done: no errors
SRCS      := $(wildcard design/*.sv dv/*.sv)
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_mini_core.sv */
// Testbench for mini_core with a random instruction stream from a fixed seed.
// A reference model tracks accepted words, expected PCs and register values.
// Inputs change on the falling edge and outputs are sampled there too.
// Only the RV32I subset of the core plus a few illegal encodings is used.
module tb_mini_core import core_pkg::*; #(
    parameter int SEED = 13964
) ();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 16;
    localparam int N_IMM          = 60;
    localparam int N_REG          = 80;
    localparam int N_ILLEGAL      = 60;
    localparam int N_X0           = 60;
    localparam int N_ORDER        = 100;
    localparam int N_HALT         = 120;
    localparam int TOTAL_INSTR    = N_IMM + N_REG + N_ILLEGAL + N_X0 + N_ORDER + N_HALT;
    localparam int TIMEOUT_CYCLES = TOTAL_INSTR * (16 + 20);

    // Stimulus modes
    localparam int MODE_IMM     = 0;
    localparam int MODE_REG     = 1;
    localparam int MODE_ILLEGAL = 2;
    localparam int MODE_X0      = 3;
    localparam int MODE_MIX     = 4;
    localparam int MODE_HALT    = 5;

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] pc;
    } fetch_rec_t;

    logic        clk_i;
    logic        rst_ni;
    logic [31:0] boot_addr_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_instr_i;
    logic        fetch_ack_o;
    logic        halt_i;
    logic        commit_valid_o;
    commit_rec_t commit_o;

    fetch_rec_t  model_q [$];
    logic [31:0] model_regs [32];
    logic [31:0] next_pc;
    int          error_count;
    int          accepted_count;
    int          committed_count;

    mini_core #(
        .SB_DEPTH ( 4 )
    ) mini_core_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .boot_addr_i    ( boot_addr_i    ),
        .fetch_valid_i  ( fetch_valid_i  ),
        .fetch_instr_i  ( fetch_instr_i  ),
        .fetch_ack_o    ( fetch_ack_o    ),
        .halt_i         ( halt_i         ),
        .commit_valid_o ( commit_valid_o ),
        .commit_o       ( commit_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Instruction encoding and the reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] illegal_word();
        logic [31:0] r;
        logic [31:0] w;
        r = $urandom;
        case ($urandom_range(0, 3))
            0:       w = {r[31:7], 7'b1100011};
            1:       w = {r[31:15], 3'b001, r[11:7], 7'b0010011};
            2:       w = {7'b0000001, r[24:12], r[11:7], 7'b0110011};
            default: w = {r[31:7], 7'b0000011};
        endcase
        return w;
    endfunction

    function automatic logic [31:0] gen_word(input int mode);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        int unsigned pick;
        logic [31:0] w;
        rd    = 5'($urandom_range(1, 7));
        rs1   = 5'($urandom_range(0, 7));
        rs2   = 5'($urandom_range(0, 7));
        imm   = 12'($urandom);
        upper = 20'($urandom);
        if (mode == MODE_X0) begin
            if ($urandom_range(0, 1) == 0) rd = 5'd0;
            if ($urandom_range(0, 2) == 0) rs1 = 5'd0;
            if ($urandom_range(0, 2) == 0) rs2 = 5'd0;
        end
        pick = (mode == MODE_IMM) ? $urandom_range(0, 4) : $urandom_range(0, 9);
        case (pick)
            0:       w = {imm, rs1, 3'b000, rd, 7'b0010011};
            1:       w = {imm, rs1, 3'b100, rd, 7'b0010011};
            2:       w = {imm, rs1, 3'b110, rd, 7'b0010011};
            3:       w = {imm, rs1, 3'b111, rd, 7'b0010011};
            4:       w = {upper, rd, 7'b0110111};
            5:       w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            6:       w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            7:       w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            8:       w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            default: w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
        endcase
        if (mode == MODE_ILLEGAL && $urandom_range(0, 3) == 0) w = illegal_word();
        if (mode >= MODE_MIX && $urandom_range(0, 15) == 0) w = illegal_word();
        return w;
    endfunction

    // RV32I semantics for the supported subset
    function automatic void model_exec(input logic [31:0] word, output logic legal,
                                       output logic [31:0] result);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        imm_i  = {{20{word[31]}}, word[31:20]};
        legal  = 1'b1;
        result = '0;
        if (word[6:0] == 7'b0010011) begin
            case (word[14:12])
                3'b000:  result = a + imm_i;
                3'b100:  result = a ^ imm_i;
                3'b110:  result = a | imm_i;
                3'b111:  result = a & imm_i;
                default: legal = 1'b0;
            endcase
        end else if (word[6:0] == 7'b0110011) begin
            if (word[31:25] == 7'b0100000 && word[14:12] == 3'b000) begin
                result = a - b;
            end else if (word[31:25] != 7'b0000000) begin
                legal = 1'b0;
            end else begin
                case (word[14:12])
                    3'b000:  result = a + b;
                    3'b100:  result = a ^ b;
                    3'b110:  result = a | b;
                    3'b111:  result = a & b;
                    default: legal = 1'b0;
                endcase
            end
        end else if (word[6:0] == 7'b0110111) begin
            result = {word[31:12], 12'h000};
        end else begin
            legal = 1'b0;
        end
    endfunction

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_commit();
        fetch_rec_t  exp;
        logic        legal;
        logic [31:0] result;
        logic        exp_we;
        if (commit_valid_o) begin
            committed_count++;
            if (model_q.size() == 0) begin
                $display("Commit at pc %08h without any outstanding instruction", commit_o.pc);
                error_count++;
            end else begin
                exp = model_q.pop_front();
                model_exec(exp.word, legal, result);
                exp_we = legal && (exp.word[11:7] != 5'd0);
                check_value("commit_o.pc", commit_o.pc, exp.pc);
                check_value("commit_o.rd", 32'(commit_o.rd), 32'(exp.word[11:7]));
                check_value("commit_o.we", 32'(commit_o.we), 32'(exp_we));
                check_value("commit_o.ex_valid", 32'(commit_o.ex_valid), 32'(!legal));
                if (!legal) begin
                    check_value("commit_o.cause", 32'(commit_o.cause), 32'd2);
                    check_value("commit_o.tval", commit_o.tval, exp.word);
                end else if (exp_we) begin
                    check_value("commit_o.wdata", commit_o.wdata, result);
                    model_regs[exp.word[11:7]] = result;
                end
            end
        end
    endtask

    // One test: issue count words in the given mode, then drain the core
    task automatic run_test(input int num, input string name, input int mode,
                            input int count);
        int          issued;
        int          err_start;
        int          ack_low;
        int unsigned halt_left;
        logic        holding;
        fetch_rec_t  rec;
        issued    = 0;
        err_start = error_count;
        ack_low   = 0;
        halt_left = 0;
        holding   = 1'b0;
        while (issued < count) begin
            @(negedge clk_i);
            check_commit();
            if (!fetch_ack_o) ack_low++;
            // Halt comes in bursts, long ones for the back-pressure test
            if (halt_left > 0) begin
                halt_i = 1'b1;
                halt_left--;
            end else begin
                halt_i = 1'b0;
                if (mode == MODE_HALT && $urandom_range(0, 5) == 0) begin
                    halt_left = $urandom_range(8, 24);
                end else if ($urandom_range(0, 15) == 0) begin
                    halt_left = $urandom_range(1, 3);
                end
            end
            // A word stays on the bus until it is taken
            if (!holding) begin
                if ($urandom_range(0, 3) != 0) begin
                    fetch_valid_i = 1'b1;
                    fetch_instr_i = gen_word(mode);
                end else begin
                    fetch_valid_i = 1'b0;
                    fetch_instr_i = $urandom;
                end
            end
            if (fetch_valid_i && fetch_ack_o) begin
                rec.word = fetch_instr_i;
                rec.pc   = next_pc;
                model_q.push_back(rec);
                next_pc = next_pc + 32'd4;
                accepted_count++;
                issued++;
                holding = 1'b0;
            end else begin
                holding = fetch_valid_i;
            end
        end
        do begin
            @(negedge clk_i);
            fetch_valid_i = 1'b0;
            halt_i        = 1'b0;
            check_commit();
        end while (model_q.size() != 0);
        if (mode == MODE_HALT && ack_low == 0) begin
            $display("Halt bursts never pulled fetch_ack_o low");
            error_count++;
        end
        $display("Test %0d %-16s %0d instructions, %0d cycles without ack, %0d errors",
                 num, name, count, ack_low, error_count - err_start);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst_ni          = 1'b0;
        fetch_valid_i   = 1'b0;
        fetch_instr_i   = '0;
        halt_i          = 1'b0;
        boot_addr_i     = $urandom & 32'hFFFF_FFFC;
        next_pc         = boot_addr_i;
        error_count     = 0;
        accepted_count  = 0;
        committed_count = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_value("fetch_ack_o", 32'(fetch_ack_o), 32'd1);
        check_value("commit_valid_o", 32'(commit_valid_o), 32'd0);

        run_test(1, "immediate ops", MODE_IMM, N_IMM);
        run_test(2, "register ops", MODE_REG, N_REG);
        run_test(3, "illegal words", MODE_ILLEGAL, N_ILLEGAL);
        run_test(4, "writes to x0", MODE_X0, N_X0);
        run_test(5, "order and pcs", MODE_MIX, N_ORDER);
        run_test(6, "halt pressure", MODE_HALT, N_HALT);

        if (accepted_count != committed_count || model_q.size() != 0) begin
            $display("Accepted %0d instructions but committed %0d",
                     accepted_count, committed_count);
            error_count++;
        end
        $display("Summary: %0d accepted, %0d committed, %0d errors",
                 accepted_count, committed_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* design/mini_core.sv */
// Top level of the in-order decode, queue and commit path.
// No interrupts, branches or memory access. SB_DEPTH sets the queue
// depth and must be a power of two.
module mini_core import core_pkg::*; #(
    parameter int unsigned SB_DEPTH = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    input  logic            fetch_valid_i,
    input  logic [31:0]     fetch_instr_i,
    output logic            fetch_ack_o,
    input  logic            halt_i,
    output logic            commit_valid_o,
    output commit_rec_t     commit_o
);

    // ------------------------------------------------------------------------
    // Decode <-> queue <-> commit
    // ------------------------------------------------------------------------
    logic      entry_valid;
    sb_entry_t entry;
    logic      full;
    logic      sb_push;
    sb_entry_t head;
    logic      not_empty;
    logic      pop;

    // Held entry only enters when there is room
    assign sb_push = entry_valid & ~full;

    instr_decoder instr_decoder_i (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .fetch_valid_i ( fetch_valid_i ),
        .fetch_instr_i ( fetch_instr_i ),
        .fetch_ack_o   ( fetch_ack_o   ),
        .entry_valid_o ( entry_valid   ),
        .entry_o       ( entry         ),
        .full_i        ( full          )
    );

    scoreboard_fifo #(
        .DEPTH ( SB_DEPTH )
    ) scoreboard_fifo_i (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .push_i      ( sb_push   ),
        .entry_i     ( entry     ),
        .full_o      ( full      ),
        .pop_i       ( pop       ),
        .head_o      ( head      ),
        .not_empty_o ( not_empty )
    );

    commit_stage commit_stage_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .head_i         ( head           ),
        .not_empty_i    ( not_empty      ),
        .halt_i         ( halt_i         ),
        .pop_o          ( pop            ),
        .commit_valid_o ( commit_valid_o ),
        .commit_o       ( commit_o       )
    );

endmodule

/* design/commit_stage.sv */
// Commit stage with the integer register file and a single-cycle ALU.
// One instruction retires per cycle at most. Halt only blocks pops and
// never discards an entry. Illegal entries retire as exceptions with
// cause 2 and the instruction word as tval; they do not write rd.
module commit_stage import core_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  sb_entry_t   head_i,
    input  logic        not_empty_i,
    input  logic        halt_i,
    output logic        pop_o,
    output logic        commit_valid_o,
    output commit_rec_t commit_o
);

    // x0 is not stored
    logic [XLEN-1:0] regs_q [1:31];

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic            rf_we;
    logic            commit_valid_q;
    commit_rec_t     commit_q;
    commit_rec_t     rec_d;

    assign pop_o = not_empty_i & ~halt_i;

    // ------------------------------------------------------------------------
    // Operand read
    // ------------------------------------------------------------------------
    assign rs1_data  = (head_i.rs1 == '0) ? '0 : regs_q[head_i.rs1];
    assign rs2_data  = (head_i.rs2 == '0) ? '0 : regs_q[head_i.rs2];
    assign operand_b = head_i.use_imm ? head_i.imm : rs2_data;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (head_i.alu_op)
            ALU_ADD:    alu_result = rs1_data + operand_b;
            ALU_SUB:    alu_result = rs1_data - operand_b;
            ALU_XOR:    alu_result = rs1_data ^ operand_b;
            ALU_OR:     alu_result = rs1_data | operand_b;
            ALU_AND:    alu_result = rs1_data & operand_b;
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // Writes to x0 and faulting instructions are dropped
    assign rf_we = pop_o & ~head_i.illegal & (head_i.rd != '0);

    // Commit record for the instruction at the head
    always_comb begin
        rec_d          = '0;
        rec_d.pc       = head_i.pc;
        rec_d.rd       = head_i.rd;
        rec_d.wdata    = alu_result;
        rec_d.we       = ~head_i.illegal & (head_i.rd != '0);
        rec_d.ex_valid = head_i.illegal;
        if (head_i.illegal) begin
            rec_d.wdata = '0;
            rec_d.cause = CAUSE_ILLEGAL;
            rec_d.tval  = XLEN'(head_i.instr);
        end
    end

    // ------------------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rf_we) begin
            regs_q[head_i.rd] <= alu_result;
        end
    end

    // ------------------------------------------------------------------------
    // Commit output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            commit_q <= rec_d;
        end
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_o       = commit_q;

    // A waiting head entry stays in place until it is popped
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        not_empty_i && !pop_o |=> not_empty_i && $stable(head_i));

endmodule

/* design/scoreboard_fifo.sv */
// In-order queue of decoded entries between decode and commit.
// DEPTH must be a power of two so the pointers wrap on their own.
// Head is read straight from storage, so a push is visible next cycle.
// Push and pop may occur in the same cycle.
module scoreboard_fifo import core_pkg::*; #(
    parameter int unsigned DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      push_i,
    input  sb_entry_t entry_i,
    output logic      full_o,
    input  logic      pop_i,
    output sb_entry_t head_o,
    output logic      not_empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    sb_entry_t        mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    assign full_o      = (count_q == CNT_W'(DEPTH));
    assign not_empty_o = (count_q != '0);
    assign head_o      = mem_q[rd_ptr_q];

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // ------------------------------------------------------------------------
    // Protocol checks on both neighbours
    // ------------------------------------------------------------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> not_empty_o);

endmodule

/* design/instr_decoder.sv */
// Decode stage with a single output register.
// PCs start at boot_addr_i and step by 4 per accepted word; there is no
// branch or redirect path. boot_addr_i must stay stable while running.
// Encodings outside ADDI/XORI/ORI/ANDI/ADD/SUB/XOR/OR/AND/LUI are illegal.
module instr_decoder import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    input  logic            fetch_valid_i,
    input  logic [31:0]     fetch_instr_i,
    output logic            fetch_ack_o,
    output logic            entry_valid_o,
    output sb_entry_t       entry_o,
    input  logic            full_i
);

    logic [XLEN-1:0] pc_offset_q;
    logic            entry_valid_q;
    sb_entry_t       entry_q;
    sb_entry_t       decoded;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            accept;
    logic            pushed;

    // Held entry leaves when the queue has room
    assign pushed      = entry_valid_q & ~full_i;
    assign fetch_ack_o = ~entry_valid_q | ~full_i;
    assign accept      = fetch_valid_i & fetch_ack_o;

    assign opcode = opcode_e'(fetch_instr_i[6:0]);
    assign funct3 = fetch_instr_i[14:12];
    assign funct7 = fetch_instr_i[31:25];

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    always_comb begin
        decoded         = '0;
        decoded.pc      = boot_addr_i + pc_offset_q;
        decoded.instr   = fetch_instr_i;
        decoded.rd      = fetch_instr_i[11:7];
        decoded.rs1     = fetch_instr_i[19:15];
        decoded.rs2     = fetch_instr_i[24:20];
        decoded.alu_op  = ALU_ADD;

        case (opcode)
            OPC_OP_IMM: begin
                decoded.use_imm = 1'b1;
                decoded.imm     = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
                case (funct3)
                    3'b000:  decoded.alu_op = ALU_ADD;
                    3'b100:  decoded.alu_op = ALU_XOR;
                    3'b110:  decoded.alu_op = ALU_OR;
                    3'b111:  decoded.alu_op = ALU_AND;
                    default: decoded.illegal = 1'b1;
                endcase
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  decoded.alu_op = ALU_ADD;
                        3'b100:  decoded.alu_op = ALU_XOR;
                        3'b110:  decoded.alu_op = ALU_OR;
                        3'b111:  decoded.alu_op = ALU_AND;
                        default: decoded.illegal = 1'b1;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    decoded.alu_op = ALU_SUB;
                end else begin
                    decoded.illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                decoded.use_imm = 1'b1;
                decoded.imm     = {fetch_instr_i[31:12], 12'b0};
                decoded.alu_op  = ALU_PASS_B;
                // No source register, x0 keeps operand a at zero
                decoded.rs1     = '0;
            end
            default: decoded.illegal = 1'b1;
        endcase
    end

    // ------------------------------------------------------------------------
    // PC counter and output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_offset_q   <= '0;
            entry_valid_q <= 1'b0;
        end else if (accept) begin
            pc_offset_q   <= pc_offset_q + XLEN'(4);
            entry_valid_q <= 1'b1;
        end else if (pushed) begin
            entry_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_q <= decoded;
        end
    end

    assign entry_valid_o = entry_valid_q;
    assign entry_o       = entry_q;

    // A stalled entry must be held until the queue takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        entry_valid_o && full_i |=> entry_valid_o && $stable(entry_o));

endmodule

/* design/core_pkg.sv */
// Shared widths, encodings and record layouts for the mini core.
// Only a small RV32I subset is decoded, so opcode_e lists just the major
// opcodes in use. Data and address width is fixed at 32 bits.
package core_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;

    // Exception cause for an illegal instruction, as in mcause
    localparam logic [3:0] CAUSE_ILLEGAL = 4'd2;

    // ------------------------------------------------------------------------
    // Opcodes and ALU operations
    // ------------------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // LUI forwards the upper immediate
    } alu_op_e;

    // ------------------------------------------------------------------------
    // Decoded instruction, as held in the scoreboard queue
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  illegal;
        logic [31:0]           instr;
    } sb_entry_t;

    // ------------------------------------------------------------------------
    // Retired instruction record
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  we;
        // Exception fields, only meaningful with ex_valid set
        logic                  ex_valid;
        logic [3:0]            cause;
        logic [XLEN-1:0]       tval;
    } commit_rec_t;

endpackage
